//--- dv/mat_mul_properties.sv
`timescale 1ns/1ns

module mat_mul_properties (
    input logic clk,
    input logic rst,
    input logic psel,
    input logic penable,
    input logic pready,
    input logic pslverr,
    input logic a_we,
    input logic b_we,
    input logic c_we,
    input logic busy,
    input logic done_pulse
);

    // error response only in the cycle that completes an access
    slverr_in_access: assert property (@(posedge clk) disable iff (rst)
        pslverr |-> (psel && penable && pready))
        else $error("pslverr high outside a completed access phase");

    // host writes into A or B never overlap a run
    no_host_write_busy: assert property (@(posedge clk) disable iff (rst)
        busy |-> !(a_we || b_we))
        else $error("memory write enable high while the engine is busy");

    c_write_in_run: assert property (@(posedge clk) disable iff (rst)
        $rose(c_we) |-> busy)
        else $error("c_we rose while the engine is idle");

    done_ends_busy: assert property (@(posedge clk) disable iff (rst)
        done_pulse |=> !busy)
        else $error("busy still high one cycle after done_pulse");

endmodule

bind mat_mul_top mat_mul_properties props0 (
    .clk(clk), .rst(rst), .psel(psel), .penable(penable), .pready(pready),
    .pslverr(pslverr), .a_we(a_we), .b_we(b_we), .c_we(c_we), .busy(busy),
    .done_pulse(done_pulse)
);

//--- dv/mat_mul_tb.sv
`timescale 1ns/1ns

module mat_mul_tb;

    localparam int dim_log2   = 3;
    localparam int side       = 1 << dim_log2;
    localparam int n_elem     = side * side;
    localparam int poll_limit = side * side * side + 100;

    logic                   clk;
    logic                   rst;
    logic                   psel;
    logic                   penable;
    logic                   pwrite;
    mat_mul_pkg::apb_addr_t paddr;
    mat_mul_pkg::apb_data_t pwdata;
    mat_mul_pkg::apb_data_t prdata;
    logic                   pready;
    logic                   pslverr;

    int unsigned mat_a [n_elem];
    int unsigned mat_b [n_elem];
    int unsigned ref_c [n_elem];
    int unsigned cycle_cnt = 0;
    int          errors = 0;
    int          tests_passed = 0;
    int          tests_failed = 0;

    mat_mul_top #(.dim_log2(dim_log2)) dut0 (
        .clk(clk), .rst(rst), .psel(psel), .penable(penable), .pwrite(pwrite),
        .paddr(paddr), .pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    task automatic report_mismatch(input string name, input int unsigned exp_val,
                                   input int unsigned act_val);
        $display("[FAIL] t=%0t %s expected 0x%0h got 0x%0h", $time, name, exp_val, act_val);
        errors++;
    endtask

    function automatic mat_mul_pkg::apb_addr_t elem_addr(input mat_mul_pkg::apb_addr_t base,
                                                         input int n);
        return base + mat_mul_pkg::apb_addr_t'(4 * n);
    endfunction

    // one APB transfer, completion sampled on the falling edge
    task automatic apb_xfer(input logic wr, input mat_mul_pkg::apb_addr_t addr,
                            input mat_mul_pkg::apb_data_t wdata,
                            output mat_mul_pkg::apb_data_t rdata, output logic err);
        int waits;
        waits = 0;
        rdata = '0;
        err = 1'b0;
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= wr;
        paddr   <= addr;
        pwdata  <= wdata;
        @(posedge clk);
        penable <= 1'b1;
        @(negedge clk);
        while (!pready && waits < 16) begin
            waits++;
            @(negedge clk);
        end
        if (!pready) begin
            $display("APB transfer to 0x%04h saw no pready within 16 cycles", addr);
            errors++;
            err = 1'b1;
        end else begin
            rdata = prdata;
            err = pslverr;
        end
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic apb_write(input mat_mul_pkg::apb_addr_t addr,
                             input mat_mul_pkg::apb_data_t data, output logic err);
        mat_mul_pkg::apb_data_t unused;
        apb_xfer(1'b1, addr, data, unused, err);
    endtask

    task automatic apb_read(input mat_mul_pkg::apb_addr_t addr,
                            output mat_mul_pkg::apb_data_t data, output logic err);
        apb_xfer(1'b0, addr, '0, data, err);
    endtask

    // C(i,j) is the sum over k of A(i,k) * B(k,j)
    function automatic void compute_ref();
        int i;
        int j;
        int k;
        int unsigned sum;
        for (i = 0; i < side; i++) begin
            for (j = 0; j < side; j++) begin
                sum = 0;
                for (k = 0; k < side; k++) begin
                    sum += mat_a[i * side + k] * mat_b[k * side + j];
                end
                ref_c[i * side + j] = sum;
            end
        end
    endfunction

    task automatic load_matrices();
        logic err;
        int n;
        for (n = 0; n < n_elem; n++) begin
            apb_write(elem_addr(mat_mul_pkg::win_a, n), mat_a[n], err);
            if (err) begin
                report_mismatch($sformatf("pslverr a[%0d]", n), 0, err);
            end
            apb_write(elem_addr(mat_mul_pkg::win_b, n), mat_b[n], err);
            if (err) begin
                report_mismatch($sformatf("pslverr b[%0d]", n), 0, err);
            end
        end
    endtask

    task automatic start_engine();
        logic err;
        apb_write(mat_mul_pkg::reg_ctrl, 32'h1, err);
        if (err) begin
            report_mismatch("pslverr", 0, err);
        end
    endtask

    task automatic wait_done();
        mat_mul_pkg::apb_data_t st;
        logic err;
        int unsigned t0;
        t0 = cycle_cnt;
        st = '0;
        while (!st[1] && (cycle_cnt - t0) < poll_limit) begin
            apb_read(mat_mul_pkg::reg_status, st, err);
        end
        if (!st[1]) begin
            $display("engine did not report done within %0d cycles", poll_limit);
            errors++;
        end else if (st != 32'h2) begin
            report_mismatch("status", 32'h2, st);
        end
    endtask

    task automatic check_c();
        mat_mul_pkg::apb_data_t rd;
        logic err;
        int n;
        for (n = 0; n < n_elem; n++) begin
            apb_read(elem_addr(mat_mul_pkg::win_c, n), rd, err);
            if (err) begin
                report_mismatch($sformatf("pslverr c[%0d]", n), 0, err);
            end else if (rd != ref_c[n]) begin
                report_mismatch($sformatf("c[%0d]", n), ref_c[n], rd);
            end
        end
    endtask

    task automatic end_test(input string name, input int err_before);
        if (errors == err_before) begin
            tests_passed++;
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", name, errors - err_before);
        end
    endtask

    task automatic test_reset();
        mat_mul_pkg::apb_data_t rd;
        logic err;
        int e0;
        e0 = errors;
        apb_read(mat_mul_pkg::reg_status, rd, err);
        if (rd != 0) begin
            report_mismatch("status", 0, rd);
        end
        if (err) begin
            report_mismatch("pslverr", 0, err);
        end
        // unmapped register offset
        apb_read(16'h0010, rd, err);
        if (rd != 0) begin
            report_mismatch("prdata", 0, rd);
        end
        if (err) begin
            report_mismatch("pslverr", 0, err);
        end
        end_test("reset_state", e0);
    endtask

    task automatic test_windows();
        mat_mul_pkg::apb_data_t rd;
        logic err;
        int e0;
        int n;
        e0 = errors;
        for (n = 0; n < n_elem; n++) begin
            mat_a[n] = $urandom & 32'hff;
            mat_b[n] = $urandom & 32'hff;
        end
        load_matrices();
        for (n = 0; n < n_elem; n++) begin
            apb_read(elem_addr(mat_mul_pkg::win_a, n), rd, err);
            if (err || rd != mat_a[n]) begin
                report_mismatch($sformatf("a[%0d]", n), mat_a[n], rd);
            end
            apb_read(elem_addr(mat_mul_pkg::win_b, n), rd, err);
            if (err || rd != mat_b[n]) begin
                report_mismatch($sformatf("b[%0d]", n), mat_b[n], rd);
            end
        end
        apb_write(elem_addr(mat_mul_pkg::win_c, 3), 32'h55, err);
        if (!err) begin
            report_mismatch("pslverr", 1, err);
        end
        end_test("memory_windows", e0);
    endtask

    task automatic test_identity();
        int e0;
        int n;
        e0 = errors;
        for (n = 0; n < n_elem; n++) begin
            mat_a[n] = $urandom & 32'hff;
            mat_b[n] = (n / side == n % side) ? 1 : 0;
            ref_c[n] = mat_a[n];
        end
        load_matrices();
        start_engine();
        wait_done();
        check_c();
        end_test("identity_multiply", e0);
    endtask

    task automatic test_random();
        int e0;
        int n;
        e0 = errors;
        for (n = 0; n < n_elem; n++) begin
            mat_a[n] = $urandom & 32'hff;
            mat_b[n] = $urandom & 32'hff;
        end
        compute_ref();
        load_matrices();
        start_engine();
        wait_done();
        check_c();
        end_test("random_multiply", e0);
    endtask

    task automatic test_busy();
        mat_mul_pkg::apb_data_t rd;
        logic err;
        int e0;
        int n;
        e0 = errors;
        for (n = 0; n < n_elem; n++) begin
            mat_a[n] = $urandom & 32'hff;
            mat_b[n] = $urandom & 32'hff;
        end
        compute_ref();
        load_matrices();
        start_engine();
        apb_read(elem_addr(mat_mul_pkg::win_a, 0), rd, err);
        if (!err) begin
            report_mismatch("pslverr", 1, err);
        end
        // a changed A element must not reach the result
        apb_write(elem_addr(mat_mul_pkg::win_a, 0), ~mat_a[0] & 32'hff, err);
        if (!err) begin
            report_mismatch("pslverr", 1, err);
        end
        apb_write(mat_mul_pkg::reg_ctrl, 32'h1, err);
        if (err) begin
            report_mismatch("pslverr", 0, err);
        end
        apb_read(mat_mul_pkg::reg_status, rd, err);
        if (rd != 32'h1) begin
            report_mismatch("status", 32'h1, rd);
        end
        wait_done();
        check_c();
        end_test("busy_protection", e0);
    endtask

    task automatic test_full_scale();
        mat_mul_pkg::apb_data_t rd;
        logic err;
        int e0;
        int n;
        e0 = errors;
        for (n = 0; n < n_elem; n++) begin
            mat_a[n] = 255;
            mat_b[n] = 255;
            ref_c[n] = side * 65025;
        end
        load_matrices();
        start_engine();
        wait_done();
        check_c();
        // second run, done must drop until it completes
        start_engine();
        apb_read(mat_mul_pkg::reg_status, rd, err);
        if (rd != 32'h1) begin
            report_mismatch("status", 32'h1, rd);
        end
        wait_done();
        check_c();
        end_test("full_scale", e0);
    endtask

    initial begin
        rst     <= 1'b1;
        psel    <= 1'b0;
        penable <= 1'b0;
        pwrite  <= 1'b0;
        paddr   <= '0;
        pwdata  <= '0;
        void'($urandom(32'h478674c6));
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        test_reset();
        test_windows();
        test_identity();
        test_random();
        test_busy();
        test_full_scale();
        $display("summary: %0d tests passed, %0d tests failed, %0d errors",
                 tests_passed, tests_failed, errors);
        if (errors == 0 && tests_failed == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

//--- mat_mul.f
src/mat_mul_pkg.sv
src/mat_sram.sv
src/mat_addr_gen.sv
src/mat_mac.sv
src/mat_mul_regs.sv
src/mat_mul_top.sv
dv/mat_mul_properties.sv
dv/mat_mul_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the matrix multiply testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module mat_mul_tb \
    -f mat_mul.f \
    -o mat_mul_sim
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

sim_out=$(./obj_dir/mat_mul_sim)
status=$?
echo "$sim_out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$sim_out" | grep -q -F "*** TEST PASSED ***"; then
    exit 0
fi
echo "pass message not found in simulation output"
exit 1

//--- src/mat_addr_gen.sv
`timescale 1ns/1ns

module mat_addr_gen #(
    parameter int dim_log2 = 6
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   start,
    output logic                   busy,
    output logic                   done_pulse,
    output logic                   rd_en,
    output mat_mul_pkg::mem_addr_t a_addr,
    output mat_mul_pkg::mem_addr_t b_addr,
    output logic                   term_valid,
    output logic                   term_first,
    output logic                   term_last,
    output mat_mul_pkg::mem_addr_t c_addr
);

    localparam int cnt_w = 3 * dim_log2;

    mat_mul_pkg::eng_state_t state;

    // {i, j, k} with k as the fastest index
    logic [cnt_w-1:0]    cnt;
    logic [dim_log2-1:0] row_i;
    logic [dim_log2-1:0] col_j;
    logic [dim_log2-1:0] term_k;
    logic [1:0]          drain_cnt;

    assign row_i  = cnt[cnt_w-1 -: dim_log2];
    assign col_j  = cnt[2*dim_log2-1 -: dim_log2];
    assign term_k = cnt[dim_log2-1:0];

    assign busy  = (state != mat_mul_pkg::eng_idle);
    assign rd_en = (state == mat_mul_pkg::eng_run);

    // third drain cycle, the last c write has landed by now
    assign done_pulse = (state == mat_mul_pkg::eng_drain) && (drain_cnt == 2'd2);

    // a walks along row i, b walks down column j
    assign a_addr = mat_mul_pkg::mem_addr_t'({row_i, term_k});
    assign b_addr = mat_mul_pkg::mem_addr_t'({term_k, col_j});

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= mat_mul_pkg::eng_idle;
            cnt       <= '0;
            drain_cnt <= '0;
        end else begin
            case (state)
                mat_mul_pkg::eng_idle: begin
                    if (start) begin
                        state <= mat_mul_pkg::eng_run;
                        cnt   <= '0;
                    end
                end
                mat_mul_pkg::eng_run: begin
                    cnt <= cnt + 1'b1;
                    if (&cnt) begin
                        state     <= mat_mul_pkg::eng_drain;
                        drain_cnt <= '0;
                    end
                end
                mat_mul_pkg::eng_drain: begin
                    drain_cnt <= drain_cnt + 1'b1;
                    if (done_pulse) begin
                        state <= mat_mul_pkg::eng_idle;
                    end
                end
                default: begin
                    state <= mat_mul_pkg::eng_idle;
                end
            endcase
        end
    end

    // term markers lag the address by the array read latency
    always_ff @(posedge clk) begin
        if (rst) begin
            term_valid <= 1'b0;
            term_first <= 1'b0;
            term_last  <= 1'b0;
        end else begin
            term_valid <= rd_en;
            term_first <= rd_en && (term_k == '0);
            term_last  <= rd_en && (&term_k);
        end
    end

    always_ff @(posedge clk) begin
        c_addr <= mat_mul_pkg::mem_addr_t'({row_i, col_j});
    end

endmodule

//--- src/mat_mac.sv
`timescale 1ns/1ns

module mat_mac (
    input  logic                   clk,
    input  logic                   rst,
    input  mat_mul_pkg::elem_t     a_data,
    input  mat_mul_pkg::elem_t     b_data,
    input  logic                   term_valid,
    input  logic                   term_first,
    input  logic                   term_last,
    input  mat_mul_pkg::mem_addr_t c_addr,
    output logic                   c_we,
    output mat_mul_pkg::mem_addr_t c_waddr,
    output mat_mul_pkg::acc_t      c_wdata
);

    logic [2*mat_mul_pkg::elem_w-1:0] product;
    mat_mul_pkg::acc_t                acc;
    mat_mul_pkg::acc_t                acc_next;

    assign product = a_data * b_data;

    // first term of a dot product starts a fresh sum
    always_comb begin
        if (term_first) begin
            acc_next = mat_mul_pkg::acc_t'(product);
        end else begin
            acc_next = acc + mat_mul_pkg::acc_t'(product);
        end
    end

    always_ff @(posedge clk) begin
        if (term_valid) begin
            acc <= acc_next;
        end
    end

    // completed sum goes out on its own register, so the
    // accumulator is free for the next dot product right away
    always_ff @(posedge clk) begin
        if (rst) begin
            c_we <= 1'b0;
        end else begin
            c_we <= term_valid && term_last;
        end
    end

    always_ff @(posedge clk) begin
        if (term_valid && term_last) begin
            c_waddr <= c_addr;
            c_wdata <= acc_next;
        end
    end

endmodule

//--- src/mat_mul_pkg.sv
package mat_mul_pkg;

    // widths
    parameter int elem_w     = 8;
    parameter int acc_w      = 22;
    parameter int mem_addr_w = 12;
    parameter int apb_addr_w = 16;
    parameter int apb_data_w = 32;

    // a or b element, unsigned
    typedef logic [elem_w-1:0]     elem_t;
    // c element, holds a 64-term sum of 8-bit products
    typedef logic [acc_w-1:0]      acc_t;
    // word address into any of the three arrays, 64x64 max
    typedef logic [mem_addr_w-1:0] mem_addr_t;
    typedef logic [apb_addr_w-1:0] apb_addr_t;
    typedef logic [apb_data_w-1:0] apb_data_t;

    typedef enum logic [1:0] {
        eng_idle,
        eng_run,
        eng_drain
    } eng_state_t;

    // control register, bit 0 starts a run
    localparam apb_addr_t reg_ctrl   = 16'h0000;
    // status register, bit 0 busy, bit 1 sticky done
    localparam apb_addr_t reg_status = 16'h0004;

    // memory windows, one element per 32-bit word
    localparam apb_addr_t win_a = 16'h4000;
    localparam apb_addr_t win_b = 16'h8000;
    localparam apb_addr_t win_c = 16'hC000;

endpackage

//--- src/mat_mul_regs.sv
`timescale 1ns/1ns

module mat_mul_regs #(
    parameter int dim_log2 = 6
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   psel,
    input  logic                   penable,
    input  logic                   pwrite,
    input  mat_mul_pkg::apb_addr_t paddr,
    input  mat_mul_pkg::apb_data_t pwdata,
    output mat_mul_pkg::apb_data_t prdata,
    output logic                   pready,
    output logic                   pslverr,
    output logic                   start,
    input  logic                   busy,
    input  logic                   done_pulse,
    output mat_mul_pkg::mem_addr_t host_addr,
    output mat_mul_pkg::elem_t     host_wdata,
    output logic                   a_we,
    output logic                   b_we,
    output logic                   a_re,
    output logic                   b_re,
    output logic                   c_re,
    input  mat_mul_pkg::elem_t     a_rdata,
    input  mat_mul_pkg::elem_t     b_rdata,
    input  mat_mul_pkg::acc_t      c_rdata
);

    localparam int idx_w = 2 * dim_log2;

    logic       access;
    logic [1:0] win;
    logic       is_mem;
    logic       busy_any;
    logic       mem_err;
    logic       mem_rd;
    logic       rd_pending;
    logic       done_sticky;

    assign access = psel && penable;

    // window from the top two address bits, 0 is the register space
    assign win    = paddr[15:14];
    assign is_mem = (win != 2'b00);

    // a start still in flight counts as busy
    assign busy_any = busy || start;

    assign mem_err = is_mem && (busy_any || (pwrite && (win == mat_mul_pkg::win_c[15:14])));
    assign mem_rd  = access && is_mem && !pwrite && !mem_err;

    // element n sits at window + 4n
    assign host_addr  = mat_mul_pkg::mem_addr_t'(paddr[idx_w+1:2]);
    assign host_wdata = pwdata[mat_mul_pkg::elem_w-1:0];

    assign a_we = access && pwrite && !mem_err && (win == mat_mul_pkg::win_a[15:14]);
    assign b_we = access && pwrite && !mem_err && (win == mat_mul_pkg::win_b[15:14]);

    // read strobes only in the first access cycle
    assign a_re = mem_rd && !rd_pending && (win == mat_mul_pkg::win_a[15:14]);
    assign b_re = mem_rd && !rd_pending && (win == mat_mul_pkg::win_b[15:14]);
    assign c_re = mem_rd && !rd_pending && (win == mat_mul_pkg::win_c[15:14]);

    // one wait state while the array read completes
    assign pready  = access && !(mem_rd && !rd_pending);
    assign pslverr = access && mem_err;

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_pending <= 1'b0;
        end else begin
            rd_pending <= mem_rd && !rd_pending;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            start <= 1'b0;
        end else begin
            start <= access && pwrite && (paddr == mat_mul_pkg::reg_ctrl) && pwdata[0]
                     && !busy_any;
        end
    end

    // sticky done, cleared by the next start
    always_ff @(posedge clk) begin
        if (rst) begin
            done_sticky <= 1'b0;
        end else if (start) begin
            done_sticky <= 1'b0;
        end else if (done_pulse) begin
            done_sticky <= 1'b1;
        end
    end

    always_comb begin
        prdata = '0;
        if (!mem_err) begin
            case (win)
                2'b00: begin
                    if (paddr == mat_mul_pkg::reg_status) begin
                        prdata = mat_mul_pkg::apb_data_t'({done_sticky, busy});
                    end
                end
                2'b01: prdata = mat_mul_pkg::apb_data_t'(a_rdata);
                2'b10: prdata = mat_mul_pkg::apb_data_t'(b_rdata);
                default: prdata = mat_mul_pkg::apb_data_t'(c_rdata);
            endcase
        end
    end

endmodule

//--- src/mat_mul_top.sv
`timescale 1ns/1ns

module mat_mul_top #(
    parameter int dim_log2 = 6
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   psel,
    input  logic                   penable,
    input  logic                   pwrite,
    input  mat_mul_pkg::apb_addr_t paddr,
    input  mat_mul_pkg::apb_data_t pwdata,
    output mat_mul_pkg::apb_data_t prdata,
    output logic                   pready,
    output logic                   pslverr
);

    localparam int depth = 1 << (2 * dim_log2);

    // host side
    mat_mul_pkg::mem_addr_t host_addr;
    mat_mul_pkg::elem_t     host_wdata;
    logic                   a_we;
    logic                   b_we;
    logic                   a_re;
    logic                   b_re;
    logic                   c_re;
    mat_mul_pkg::elem_t     a_rdata;
    mat_mul_pkg::elem_t     b_rdata;
    mat_mul_pkg::acc_t      c_rdata;

    // engine side
    logic                   start;
    logic                   busy;
    logic                   done_pulse;
    logic                   rd_en;
    mat_mul_pkg::mem_addr_t a_addr;
    mat_mul_pkg::mem_addr_t b_addr;
    mat_mul_pkg::elem_t     a_data;
    mat_mul_pkg::elem_t     b_data;
    logic                   term_valid;
    logic                   term_first;
    logic                   term_last;
    mat_mul_pkg::mem_addr_t c_addr;
    logic                   c_we;
    mat_mul_pkg::mem_addr_t c_waddr;
    mat_mul_pkg::acc_t      c_wdata;

    mat_mul_regs #(.dim_log2(dim_log2)) regs0 (
        .clk(clk), .rst(rst),
        .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata),
        .prdata(prdata), .pready(pready), .pslverr(pslverr),
        .start(start), .busy(busy), .done_pulse(done_pulse),
        .host_addr(host_addr), .host_wdata(host_wdata),
        .a_we(a_we), .b_we(b_we), .a_re(a_re), .b_re(b_re), .c_re(c_re),
        .a_rdata(a_rdata), .b_rdata(b_rdata), .c_rdata(c_rdata)
    );

    mat_addr_gen #(.dim_log2(dim_log2)) addr_gen0 (
        .clk(clk), .rst(rst), .start(start),
        .busy(busy), .done_pulse(done_pulse), .rd_en(rd_en),
        .a_addr(a_addr), .b_addr(b_addr),
        .term_valid(term_valid), .term_first(term_first), .term_last(term_last),
        .c_addr(c_addr)
    );

    mat_mac mac0 (
        .clk(clk), .rst(rst), .a_data(a_data), .b_data(b_data),
        .term_valid(term_valid), .term_first(term_first), .term_last(term_last),
        .c_addr(c_addr), .c_we(c_we), .c_waddr(c_waddr), .c_wdata(c_wdata)
    );

    mat_sram #(.width(mat_mul_pkg::elem_w), .depth(depth)) mem_a (
        .clk(clk), .host_addr(host_addr), .host_we(a_we), .host_re(a_re),
        .host_wdata(host_wdata), .host_rdata(a_rdata),
        .eng_addr(a_addr), .eng_we(1'b0), .eng_re(rd_en), .eng_wdata('0), .eng_rdata(a_data)
    );

    mat_sram #(.width(mat_mul_pkg::elem_w), .depth(depth)) mem_b (
        .clk(clk), .host_addr(host_addr), .host_we(b_we), .host_re(b_re),
        .host_wdata(host_wdata), .host_rdata(b_rdata),
        .eng_addr(b_addr), .eng_we(1'b0), .eng_re(rd_en), .eng_wdata('0), .eng_rdata(b_data)
    );

    // c is written by the engine and only read by the host
    mat_sram #(.width(mat_mul_pkg::acc_w), .depth(depth)) mem_c (
        .clk(clk), .host_addr(host_addr), .host_we(1'b0), .host_re(c_re),
        .host_wdata('0), .host_rdata(c_rdata),
        .eng_addr(c_waddr), .eng_we(c_we), .eng_re(1'b0), .eng_wdata(c_wdata), .eng_rdata()
    );

endmodule

//--- src/mat_sram.sv
`timescale 1ns/1ns

module mat_sram #(
    parameter int width = 8,
    parameter int depth = 4096
) (
    input  logic                         clk,
    input  mat_mul_pkg::mem_addr_t       host_addr,
    input  logic                         host_we,
    input  logic                         host_re,
    input  logic [width-1:0]             host_wdata,
    output logic [width-1:0]             host_rdata,
    input  mat_mul_pkg::mem_addr_t       eng_addr,
    input  logic                         eng_we,
    input  logic                         eng_re,
    input  logic [width-1:0]             eng_wdata,
    output logic [width-1:0]             eng_rdata
);

    localparam int aw = $clog2(depth);

    logic [width-1:0] mem [depth];

    // both ports share one process, the regs block keeps them apart in time
    always_ff @(posedge clk) begin
        if (host_we) begin
            mem[host_addr[aw-1:0]] <= host_wdata;
        end
        if (eng_we) begin
            mem[eng_addr[aw-1:0]] <= eng_wdata;
        end
        if (host_re) begin
            host_rdata <= mem[host_addr[aw-1:0]];
        end
        if (eng_re) begin
            eng_rdata <= mem[eng_addr[aw-1:0]];
        end
    end

endmodule
